/* bench/tb_io_soc.sv */
`timescale 1ns/1ps

module tb_io_soc
  import io_pkg::*;
();

  localparam int CLKS_PER_BIT = 16;
  localparam int CLK_PERIOD   = 20;
  // five uart frames, about 60 bus operations at up to 150 cycles each, plus setup
  localparam int RUN_CYCLES   = 5 * 10 * CLKS_PER_BIT + 60 * 150 + 200;

  logic       clk;
  logic       rst;
  io_addr_t   io_addr;
  io_word_t   io_dout;
  logic       io_rd;
  logic       io_wr;
  io_word_t   io_din;
  logic       uart_tx;

  integer     seed = 32'hee76;
  int         cmp_errors = 0;  // from the compare process
  int         mon_errors = 0;  // from the uart monitor
  int         main_errors = 0; // timeouts on busy polling
  int         checks = 0;
  int         cmp_idx = 0;
  int         rx_count = 0;
  string      name_q[$];
  io_word_t   exp_q[$];
  io_word_t   act_q[$];
  logic [7:0] tx_exp_q[$];     // bytes the uart should put on the line

  io_soc #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .RAM_ADDR_W   (8)
  ) DUT (
    .sys_clk_i (clk),
    .rst_i     (rst),
    .io_addr_i (io_addr),
    .io_dout_i (io_dout),
    .io_rd_i   (io_rd),
    .io_wr_i   (io_wr),
    .io_din_o  (io_din),
    .uart_tx_o (uart_tx)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic io_addr_t page_addr(input logic [7:0] page, input reg_off_t off);
    return {page, 4'h0, off};
  endfunction

  // full 32-bit unsigned product
  function automatic logic [31:0] ref_mult(input io_word_t a, input io_word_t b);
    return {16'h0000, a} * {16'h0000, b};
  endfunction

  // quotient in the upper half, remainder in the lower half
  function automatic logic [31:0] ref_div(input io_word_t a, input io_word_t b);
    if (b == 16'd0)
      return {16'hFFFF, a}; // every trial subtract fits
    return {a / b, a % b};
  endfunction

  task automatic expect_word(input string name, input io_word_t exp, input io_word_t act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  task automatic bus_write(input io_addr_t addr, input io_word_t data);
    @(posedge clk);
    io_addr <= addr;
    io_dout <= data;
    io_wr   <= 1'b1;
    @(posedge clk);
    io_wr <= 1'b0;
  endtask

  task automatic bus_read(input io_addr_t addr, output io_word_t data);
    @(posedge clk);
    io_addr <= addr;
    io_rd   <= 1'b1;
    @(posedge clk); // data registered on this edge
    io_rd <= 1'b0;
    @(negedge clk);
    data = io_din;
  endtask

  task automatic wait_idle(input logic [7:0] page, input reg_off_t off, input string name);
    io_word_t stat;
    int       polls;
    polls = 0;
    bus_read(page_addr(page, off), stat);
    while (stat[0] && polls < 400)
    begin
      bus_read(page_addr(page, off), stat);
      polls++;
    end
    if (stat[0])
    begin
      main_errors++;
      $display("%s: busy still set after %0d status reads", name, polls);
    end
  endtask

  task automatic run_mult(input io_word_t a, input io_word_t b, input int n);
    logic [31:0] exp;
    io_word_t    lo;
    io_word_t    hi;
    exp = ref_mult(a, b);
    bus_write(page_addr(PAGE_MULT, OFF_OP_A), a);
    bus_write(page_addr(PAGE_MULT, OFF_OP_B), b);
    bus_write(page_addr(PAGE_MULT, OFF_START), 16'h0001);
    wait_idle(PAGE_MULT, OFF_STATUS, "mult");
    bus_read(page_addr(PAGE_MULT, OFF_RES_LO), lo);
    bus_read(page_addr(PAGE_MULT, OFF_RES_HI), hi);
    expect_word($sformatf("mult %0d low", n), exp[15:0], lo);
    expect_word($sformatf("mult %0d high", n), exp[31:16], hi);
  endtask

  task automatic run_div(input io_word_t a, input io_word_t b, input int n);
    logic [31:0] exp;
    io_word_t    quo;
    io_word_t    rem;
    exp = ref_div(a, b);
    bus_write(page_addr(PAGE_DIV, OFF_OP_A), a);
    bus_write(page_addr(PAGE_DIV, OFF_OP_B), b);
    bus_write(page_addr(PAGE_DIV, OFF_START), 16'h0001);
    wait_idle(PAGE_DIV, OFF_STATUS, "div");
    bus_read(page_addr(PAGE_DIV, OFF_RES_LO), quo);
    bus_read(page_addr(PAGE_DIV, OFF_RES_HI), rem);
    expect_word($sformatf("div %0d quotient", n), exp[31:16], quo);
    expect_word($sformatf("div %0d remainder", n), exp[15:0], rem);
  endtask

  // works through queued results half a cycle after they land
  always @(negedge clk)
  begin
    while (cmp_idx < act_q.size())
    begin
      if (act_q[cmp_idx] !== exp_q[cmp_idx])
      begin
        cmp_errors++;
        $display("Mismatch %s: expected %h, actual %h",
                 name_q[cmp_idx], exp_q[cmp_idx], act_q[cmp_idx]);
      end
      checks++;
      cmp_idx++;
    end
  end

  // uart receiver, samples each bit in its middle
  initial
  begin
    logic [7:0] rx_byte;
    int         b;
    #1;
    wait (rst == 1'b0);
    forever
    begin
      @(negedge uart_tx);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx !== 1'b0)
      begin
        mon_errors++;
        $display("uart: start bit was not low at mid-bit");
      end
      for (b = 0; b < 8; b++)
      begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx_byte[b] = uart_tx; // lsb first
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1)
      begin
        mon_errors++;
        $display("uart byte %0d: stop bit was low", rx_count);
      end
      if (rx_count >= tx_exp_q.size())
      begin
        mon_errors++;
        $display("uart: received byte %h that was never sent", rx_byte);
      end
      else if (rx_byte !== tx_exp_q[rx_count])
      begin
        mon_errors++;
        $display("Mismatch uart byte %0d: expected %h, actual %h",
                 rx_count, tx_exp_q[rx_count], rx_byte);
      end
      rx_count++;
    end
  end

  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
    $display("checks %0d, compare errors %0d, uart errors %0d, other errors %0d",
             checks, cmp_errors, mon_errors, main_errors);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    io_word_t    rdata;
    logic [31:0] rnd;
    io_word_t    ram_model [256];
    logic [7:0]  ram_addr [34];
    io_word_t    op_a;
    io_word_t    op_b;
    logic [7:0]  tx_byte;
    int          i;
    int          total;
    rst     <= 1'b1;
    io_addr <= '0;
    io_dout <= '0;
    io_rd   <= 1'b0;
    io_wr   <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    expect_word("reset uart line", 16'h0001, {15'd0, uart_tx});
    expect_word("reset read data", UNMAPPED_RDATA, io_din);
    bus_read(page_addr(PAGE_MULT, OFF_STATUS), rdata);
    expect_word("reset mult status", 16'h0000, rdata);
    bus_read(page_addr(PAGE_DIV, OFF_STATUS), rdata);
    expect_word("reset div status", 16'h0000, rdata);
    bus_read(16'h1200, rdata); // no peripheral on page 12
    expect_word("unmapped read", UNMAPPED_RDATA, rdata);

    for (i = 0; i < 20; i++)
    begin
      rnd = $random(seed);
      run_mult(rnd[15:0], rnd[31:16], i);
    end
    run_mult(16'h0000, 16'h0000, 20);
    run_mult(16'hFFFF, 16'hFFFF, 21);

    for (i = 0; i < 20; i++)
    begin
      rnd = $random(seed);
      run_div(rnd[15:0], rnd[31:16], i);
    end
    rnd = $random(seed);
    run_div(rnd[15:0], 16'h0000, 20);
    run_div(16'h0123, 16'h8000, 21);

    // fresh operands, then ram writes that reuse the same low address bits
    rnd  = $random(seed);
    op_a = rnd[15:0];
    op_b = rnd[31:16];
    bus_write(page_addr(PAGE_MULT, OFF_OP_A), op_a);
    bus_write(page_addr(PAGE_MULT, OFF_OP_B), op_b);
    for (i = 0; i < 34; i++)
    begin
      rnd = $random(seed);
      ram_addr[i] = (i < 2) ? 8'(i) : rnd[7:0];
      ram_model[ram_addr[i]] = rnd[31:16];
      bus_write({PAGE_RAM, ram_addr[i]}, rnd[31:16]);
    end
    for (i = 0; i < 34; i++)
    begin
      bus_read({PAGE_RAM, ram_addr[i]}, rdata);
      expect_word($sformatf("ram addr %h", ram_addr[i]), ram_model[ram_addr[i]], rdata);
    end
    bus_read(page_addr(PAGE_MULT, OFF_OP_A), rdata);
    expect_word("mult operand a after ram", op_a, rdata);
    bus_read(page_addr(PAGE_MULT, OFF_OP_B), rdata);
    expect_word("mult operand b after ram", op_b, rdata);

    for (i = 0; i < 4; i++)
    begin
      rnd     = $random(seed);
      tx_byte = rnd[7:0];
      tx_exp_q.push_back(tx_byte);
      bus_write(page_addr(PAGE_UART, OFF_TX_DATA), {8'h00, tx_byte});
      if (i == 1)
      begin
        bus_read(page_addr(PAGE_UART, OFF_TX_STAT), rdata);
        expect_word("uart busy after write", 16'h0001, rdata);
        bus_write(page_addr(PAGE_UART, OFF_TX_DATA), {8'h00, ~tx_byte}); // must be dropped
      end
      wait_idle(PAGE_UART, OFF_TX_STAT, "uart");
    end
    repeat (2 * CLKS_PER_BIT) @(negedge clk);
    expect_word("uart byte count", 16'd4, 16'(rx_count));
    expect_word("uart line idle", 16'h0001, {15'd0, uart_tx});

    repeat (2) @(negedge clk);
    total = cmp_errors + mon_errors + main_errors;
    $display("checks %0d, compare errors %0d, uart errors %0d, other errors %0d",
             checks, cmp_errors, mon_errors, main_errors);
    if (total == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* hdl/io_decode.sv */
`timescale 1ns/1ps

module io_decode
  import io_pkg::*;
(
  input  logic       sys_clk_i,
  input  logic       rst_i,
  input  logic [7:0] io_page_i,
  input  logic       io_rd_i,
  output logic       cs_mult_o,
  output logic       cs_div_o,
  output logic       cs_uart_o,
  output logic       cs_ram_o,
  input  io_word_t   mult_rdata_i,
  input  io_word_t   div_rdata_i,
  input  io_word_t   uart_rdata_i,
  input  io_word_t   ram_rdata_i,
  output io_word_t   io_din_o
);

  logic [3:0] cs_vec;
  logic [3:0] rd_sel_q; // page hit by the last read, one-hot

  // chip selects straight from the page byte
  always_comb
  begin
    case (io_page_i)
      PAGE_MULT: cs_vec = 4'b0001;
      PAGE_DIV:  cs_vec = 4'b0010;
      PAGE_UART: cs_vec = 4'b0100;
      PAGE_RAM:  cs_vec = 4'b1000;
      default:   cs_vec = 4'b0000;
    endcase
  end

  assign cs_mult_o = cs_vec[0];
  assign cs_div_o  = cs_vec[1];
  assign cs_uart_o = cs_vec[2];
  assign cs_ram_o  = cs_vec[3];

  // remember the page on the same edge the peripherals register their data
  always_ff @(posedge sys_clk_i)
  begin
    if (rst_i)
      rd_sel_q <= 4'b0000; // reads as unmapped until the first read
    else if (io_rd_i)
      rd_sel_q <= cs_vec;
  end

  always_comb
  begin
    case (rd_sel_q)
      4'b0001: io_din_o = mult_rdata_i;
      4'b0010: io_din_o = div_rdata_i;
      4'b0100: io_din_o = uart_rdata_i;
      4'b1000: io_din_o = ram_rdata_i;
      default: io_din_o = UNMAPPED_RDATA;
    endcase
  end

endmodule

/* hdl/io_pkg.sv */
package io_pkg;

  // bus word and address
  typedef logic [15:0] io_word_t;
  typedef logic [15:0] io_addr_t;

  // register offset within a page, address bits 3..0
  typedef logic [3:0]  reg_off_t;

  // page numbers, upper address byte
  localparam logic [7:0] PAGE_MULT = 8'h67;
  localparam logic [7:0] PAGE_DIV  = 8'h68;
  localparam logic [7:0] PAGE_UART = 8'h69;
  localparam logic [7:0] PAGE_RAM  = 8'h70;

  // multiplier and divider registers
  localparam reg_off_t OFF_OP_A   = 4'd0; // operand a or dividend
  localparam reg_off_t OFF_OP_B   = 4'd1; // operand b or divisor
  localparam reg_off_t OFF_START  = 4'd2; // any write starts
  localparam reg_off_t OFF_STATUS = 4'd3; // bit 0 busy
  localparam reg_off_t OFF_RES_LO = 4'd4; // product low or quotient
  localparam reg_off_t OFF_RES_HI = 4'd5; // product high or remainder

  // uart registers
  localparam reg_off_t OFF_TX_DATA = 4'd0; // low byte is sent
  localparam reg_off_t OFF_TX_STAT = 4'd1; // bit 0 busy

  // read value when no page matches
  localparam io_word_t UNMAPPED_RDATA = 16'h0666;

endpackage

/* hdl/io_soc.sv */
`timescale 1ns/1ps

module io_soc
  import io_pkg::*;
#(
  parameter int CLKS_PER_BIT = 16,
  parameter int RAM_ADDR_W   = 8
)
(
  input  logic     sys_clk_i,
  input  logic     rst_i,
  input  io_addr_t io_addr_i,
  input  io_word_t io_dout_i,
  input  logic     io_rd_i,
  input  logic     io_wr_i,
  output io_word_t io_din_o,
  output logic     uart_tx_o
);

  logic     cs_mult;
  logic     cs_div;
  logic     cs_uart;
  logic     cs_ram;
  io_word_t mult_rdata;
  io_word_t div_rdata;
  io_word_t uart_rdata;
  io_word_t ram_rdata;

  io_decode u_decode (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .io_page_i    (io_addr_i[15:8]), // page byte
    .io_rd_i      (io_rd_i),
    .cs_mult_o    (cs_mult),
    .cs_div_o     (cs_div),
    .cs_uart_o    (cs_uart),
    .cs_ram_o     (cs_ram),
    .mult_rdata_i (mult_rdata),
    .div_rdata_i  (div_rdata),
    .uart_rdata_i (uart_rdata),
    .ram_rdata_i  (ram_rdata),
    .io_din_o     (io_din_o)
  );

  periph_mult u_mult (
    .sys_clk_i (sys_clk_i),
    .rst_i     (rst_i),
    .cs_i      (cs_mult),
    .rd_i      (io_rd_i),
    .wr_i      (io_wr_i),
    .addr_i    (io_addr_i[3:0]),
    .wdata_i   (io_dout_i),
    .rdata_o   (mult_rdata)
  );

  periph_div u_div (
    .sys_clk_i (sys_clk_i),
    .rst_i     (rst_i),
    .cs_i      (cs_div),
    .rd_i      (io_rd_i),
    .wr_i      (io_wr_i),
    .addr_i    (io_addr_i[3:0]),
    .wdata_i   (io_dout_i),
    .rdata_o   (div_rdata)
  );

  periph_uart #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart (
    .sys_clk_i (sys_clk_i),
    .rst_i     (rst_i),
    .cs_i      (cs_uart),
    .rd_i      (io_rd_i),
    .wr_i      (io_wr_i),
    .addr_i    (io_addr_i[3:0]),
    .wdata_i   (io_dout_i),
    .rdata_o   (uart_rdata),
    .uart_tx_o (uart_tx_o)
  );

  periph_dpram #(
    .RAM_ADDR_W (RAM_ADDR_W)
  ) u_dpram (
    .sys_clk_i (sys_clk_i),
    .cs_i      (cs_ram),
    .rd_i      (io_rd_i),
    .wr_i      (io_wr_i),
    .addr_i    (io_addr_i[RAM_ADDR_W-1:0]), // word address within the page
    .wdata_i   (io_dout_i),
    .rdata_o   (ram_rdata)
  );

endmodule

/* hdl/periph_div.sv */
`timescale 1ns/1ps

module periph_div
  import io_pkg::*;
(
  input  logic     sys_clk_i,
  input  logic     rst_i,
  input  logic     cs_i,
  input  logic     rd_i,
  input  logic     wr_i,
  input  reg_off_t addr_i,
  input  io_word_t wdata_i,
  output io_word_t rdata_o
);

  io_word_t    dividend_q;
  io_word_t    divisor_q;
  io_word_t    dvsr_run_q; // divisor held for the whole run
  io_word_t    quo_q;      // dividend bits shift out, quotient bits shift in
  io_word_t    rem_q;      // partial remainder
  logic [3:0]  bit_cnt_q;
  logic        busy_q;
  logic        wr_en;
  logic        start;
  logic [16:0] shifted;    // remainder with next dividend bit appended
  logic [17:0] trial;      // trial subtract, bit 17 is the sign

  assign wr_en   = cs_i & wr_i;
  assign start   = wr_en && (addr_i == OFF_START) && !busy_q;
  assign shifted = {rem_q, quo_q[15]};
  assign trial   = {1'b0, shifted} - {2'b00, dvsr_run_q};

  always_ff @(posedge sys_clk_i)
  begin
    if (rst_i)
    begin
      dividend_q <= '0;
      divisor_q  <= '0;
      quo_q      <= '0;
      rem_q      <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b0;
    end
    else
    begin
      if (wr_en && addr_i == OFF_OP_A)
        dividend_q <= wdata_i;
      if (wr_en && addr_i == OFF_OP_B)
        divisor_q <= wdata_i;
      if (start)
      begin
        quo_q     <= dividend_q;
        rem_q     <= '0;
        bit_cnt_q <= '0;
        busy_q    <= 1'b1;
      end
      else if (busy_q)
      begin
        if (!trial[17])
        begin
          rem_q <= trial[15:0]; // subtract fits, keep it
          quo_q <= {quo_q[14:0], 1'b1};
        end
        else
        begin
          rem_q <= shifted[15:0]; // restore
          quo_q <= {quo_q[14:0], 1'b0};
        end
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd15)
          busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk_i)
  begin
    if (start)
      dvsr_run_q <= divisor_q;
  end

  // zero divisor never goes negative, so quotient ends all ones
  always_ff @(posedge sys_clk_i)
  begin
    if (cs_i && rd_i)
    begin
      case (addr_i)
        OFF_OP_A:   rdata_o <= dividend_q;
        OFF_OP_B:   rdata_o <= divisor_q;
        OFF_STATUS: rdata_o <= {15'd0, busy_q};
        OFF_RES_LO: rdata_o <= quo_q;
        OFF_RES_HI: rdata_o <= rem_q;
        default:    rdata_o <= '0;
      endcase
    end
  end

endmodule

/* hdl/periph_dpram.sv */
`timescale 1ns/1ps

module periph_dpram
  import io_pkg::*;
#(
  parameter int RAM_ADDR_W = 8
)
(
  input  logic                  sys_clk_i,
  input  logic                  cs_i,
  input  logic                  rd_i,
  input  logic                  wr_i,
  input  logic [RAM_ADDR_W-1:0] addr_i,
  input  io_word_t              wdata_i,
  output io_word_t              rdata_o
);

  io_word_t mem [2**RAM_ADDR_W]; // contents survive reset

  always_ff @(posedge sys_clk_i)
  begin
    if (cs_i && wr_i)
      mem[addr_i] <= wdata_i;
  end

  // registered read port
  always_ff @(posedge sys_clk_i)
  begin
    if (cs_i && rd_i)
      rdata_o <= mem[addr_i];
  end

endmodule

/* hdl/periph_mult.sv */
`timescale 1ns/1ps

module periph_mult
  import io_pkg::*;
(
  input  logic     sys_clk_i,
  input  logic     rst_i,
  input  logic     cs_i,
  input  logic     rd_i,
  input  logic     wr_i,
  input  reg_off_t addr_i,
  input  io_word_t wdata_i,
  output io_word_t rdata_o
);

  io_word_t    op_a_q;
  io_word_t    op_b_q;
  io_word_t    mcand_q;   // multiplicand held for the whole run
  logic [31:0] prod_q;    // upper half accumulates, lower half shifts out multiplier
  logic [3:0]  bit_cnt_q;
  logic        busy_q;
  logic        wr_en;
  logic        start;
  logic [16:0] partial;   // upper half plus multiplicand, with carry

  assign wr_en   = cs_i & wr_i;
  assign start   = wr_en && (addr_i == OFF_START) && !busy_q; // ignored while busy
  assign partial = {1'b0, prod_q[31:16]} + (prod_q[0] ? {1'b0, mcand_q} : 17'd0);

  always_ff @(posedge sys_clk_i)
  begin
    if (rst_i)
    begin
      op_a_q    <= '0;
      op_b_q    <= '0;
      prod_q    <= '0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end
    else
    begin
      if (wr_en && addr_i == OFF_OP_A)
        op_a_q <= wdata_i;
      if (wr_en && addr_i == OFF_OP_B)
        op_b_q <= wdata_i;
      if (start)
      begin
        prod_q    <= {16'h0000, op_b_q};
        bit_cnt_q <= '0;
        busy_q    <= 1'b1;
      end
      else if (busy_q)
      begin
        prod_q    <= {partial, prod_q[15:1]}; // one multiplier bit per clock
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd15)
          busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk_i)
  begin
    if (start)
      mcand_q <= op_a_q;
  end

  always_ff @(posedge sys_clk_i)
  begin
    if (cs_i && rd_i)
    begin
      case (addr_i)
        OFF_OP_A:   rdata_o <= op_a_q;
        OFF_OP_B:   rdata_o <= op_b_q;
        OFF_STATUS: rdata_o <= {15'd0, busy_q};
        OFF_RES_LO: rdata_o <= prod_q[15:0];
        OFF_RES_HI: rdata_o <= prod_q[31:16];
        default:    rdata_o <= '0;
      endcase
    end
  end

endmodule

/* hdl/periph_uart.sv */
`timescale 1ns/1ps

module periph_uart
  import io_pkg::*;
#(
  parameter int CLKS_PER_BIT = 16
)
(
  input  logic     sys_clk_i,
  input  logic     rst_i,
  input  logic     cs_i,
  input  logic     rd_i,
  input  logic     wr_i,
  input  reg_off_t addr_i,
  input  io_word_t wdata_i,
  output io_word_t rdata_o,
  output logic     uart_tx_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } uart_state_t;

  uart_state_t      state_q;
  logic [CNT_W-1:0] baud_cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;   // byte being sent, lsb first
  logic             tx_q;
  logic             busy;
  logic             bit_done;

  assign busy      = (state_q != ST_IDLE);
  assign bit_done  = (baud_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
  assign uart_tx_o = tx_q;

  always_ff @(posedge sys_clk_i)
  begin
    if (rst_i)
    begin
      state_q    <= ST_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      shift_q    <= '0;
      tx_q       <= 1'b1; // line idles high
    end
    else
    begin
      baud_cnt_q <= bit_done ? '0 : baud_cnt_q + CNT_W'(1);
      case (state_q)
        ST_IDLE:
        begin
          baud_cnt_q <= '0;
          if (cs_i && wr_i && addr_i == OFF_TX_DATA)
          begin
            shift_q <= wdata_i[7:0];
            tx_q    <= 1'b0; // start bit
            state_q <= ST_START;
          end
        end
        ST_START:
          if (bit_done)
          begin
            tx_q      <= shift_q[0];
            bit_idx_q <= '0;
            state_q   <= ST_DATA;
          end
        ST_DATA:
          if (bit_done)
          begin
            if (bit_idx_q == 3'd7)
            begin
              tx_q    <= 1'b1; // stop bit
              state_q <= ST_STOP;
            end
            else
            begin
              tx_q      <= shift_q[1];
              shift_q   <= {1'b0, shift_q[7:1]};
              bit_idx_q <= bit_idx_q + 3'd1;
            end
          end
        default:
          if (bit_done)
            state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk_i)
  begin
    if (cs_i && rd_i)
      rdata_o <= (addr_i == OFF_TX_STAT) ? {15'd0, busy} : '0;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the I/O subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module tb_io_soc -o tb_io_soc_sim; then
  echo "verilator compile failed"
  exit 1
fi

if ! out=$(./obj_dir/tb_io_soc_sim); then
  printf '%s\n' "$out"
  echo "simulation exited with an error status"
  exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* sim.f */
hdl/io_pkg.sv
hdl/io_decode.sv
hdl/periph_mult.sv
hdl/periph_div.sv
hdl/periph_uart.sv
hdl/periph_dpram.sv
hdl/io_soc.sv
bench/tb_io_soc.sv
